// File: ao_periph_config.svh
//----------------------------------------------------------------------
// Bus widths, address map and register offsets of the AO peripherals
//----------------------------------------------------------------------
`ifndef AO_PERIPH_CONFIG_SVH
`define AO_PERIPH_CONFIG_SVH

// Register bus
`define AO_ADDR_W 32
`define AO_DATA_W 32

// Upper half-word shared by every AO address
`define AO_BASE_HI 16'h2000
`define AO_IDX_W 4
`define AO_OFS_W 12

// Peripheral slots
`define AO_IDX_SOC_CTRL 4'd0
`define AO_IDX_FAST_INTR 4'd1
`define AO_IDX_GPIO 4'd2

`define FAST_INTR_W 15
`define GPIO_W 8

// SoC control registers
`define SOC_EXIT_VALID_OFS 12'h000
`define SOC_EXIT_VALUE_OFS 12'h004
`define SOC_BOOT_SEL_OFS 12'h008

// Fast interrupt controller registers
`define FI_PENDING_OFS 12'h000
`define FI_CLEAR_OFS 12'h004
`define FI_ENABLE_OFS 12'h008

// GPIO registers
`define GPIO_IN_OFS 12'h000
`define GPIO_OUT_OFS 12'h004
`define GPIO_EN_OFS 12'h008
`define GPIO_INTR_EN_OFS 12'h00c

`endif

// File: ao_periph_pkg.sv
//----------------------------------------------------------------------
// Register bus request and response structs
// Address union with a flat and a decoded view
//----------------------------------------------------------------------
`include "ao_periph_config.svh"

package ao_periph_pkg;

  // Decoded view of a bus address
  typedef struct packed {
    logic [`AO_ADDR_W-`AO_IDX_W-`AO_OFS_W-1:0] base_hi;
    logic [`AO_IDX_W-1:0]                      idx;
    logic [`AO_OFS_W-1:0]                      ofs;
  } ao_addr_fields_t;

  typedef union packed {
    logic [`AO_ADDR_W-1:0] word;
    ao_addr_fields_t       fld;
  } ao_addr_u;

  // Request, valid is a level and ready comes back in the same cycle
  typedef struct packed {
    ao_addr_u              addr;
    logic                  write;
    logic [`AO_DATA_W-1:0] wdata;
    logic                  valid;
  } reg_req_t;

  typedef struct packed {
    logic [`AO_DATA_W-1:0] rdata;
    logic                  error;
    logic                  ready;
  } reg_rsp_t;

endpackage

// File: ao_reg_demux.sv
//----------------------------------------------------------------------
// Address decoder and request demux for the AO peripherals
// Response mux and error response for unmapped addresses
//----------------------------------------------------------------------
`timescale 1ns/1ns
`include "ao_periph_config.svh"

module ao_reg_demux (
  input  ao_periph_pkg::reg_req_t bus_req_i,
  output ao_periph_pkg::reg_rsp_t bus_rsp_o,
  output ao_periph_pkg::reg_req_t soc_req_o,
  input  ao_periph_pkg::reg_rsp_t soc_rsp_i,
  output ao_periph_pkg::reg_req_t fi_req_o,
  input  ao_periph_pkg::reg_rsp_t fi_rsp_i,
  output ao_periph_pkg::reg_req_t gpio_req_o,
  input  ao_periph_pkg::reg_rsp_t gpio_rsp_i
);
  import ao_periph_pkg::*;

  logic     base_ok;
  logic     sel_soc;
  logic     sel_fi;
  logic     sel_gpio;
  logic     mapped;
  reg_rsp_t err_rsp;

  // Upper bits must hit the AO window before any index counts
  assign base_ok  = (bus_req_i.addr.fld.base_hi == `AO_BASE_HI);
  assign sel_soc  = bus_req_i.valid && base_ok &&
                    (bus_req_i.addr.fld.idx == `AO_IDX_SOC_CTRL);
  assign sel_fi   = bus_req_i.valid && base_ok &&
                    (bus_req_i.addr.fld.idx == `AO_IDX_FAST_INTR);
  assign sel_gpio = bus_req_i.valid && base_ok &&
                    (bus_req_i.addr.fld.idx == `AO_IDX_GPIO);
  assign mapped   = sel_soc | sel_fi | sel_gpio;

  // Same request to all slots, only the selected one sees valid
  always_comb begin
    soc_req_o        = bus_req_i;
    soc_req_o.valid  = sel_soc;
    fi_req_o         = bus_req_i;
    fi_req_o.valid   = sel_fi;
    gpio_req_o       = bus_req_i;
    gpio_req_o.valid = sel_gpio;
  end

  // Unmapped access completes at once with an error
  assign err_rsp.rdata = '0;
  assign err_rsp.error = bus_req_i.valid & ~mapped;
  assign err_rsp.ready = bus_req_i.valid;

  always_comb begin
    if (sel_soc) begin
      bus_rsp_o = soc_rsp_i;
    end else if (sel_fi) begin
      bus_rsp_o = fi_rsp_i;
    end else if (sel_gpio) begin
      bus_rsp_o = gpio_rsp_i;
    end else begin
      bus_rsp_o = err_rsp;
    end
  end

endmodule

// File: soc_ctrl.sv
//----------------------------------------------------------------------
// SoC control registers with exit value, exit flag and boot select
//----------------------------------------------------------------------
`timescale 1ns/1ns
`include "ao_periph_config.svh"

module soc_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  ao_periph_pkg::reg_req_t reg_req_i,
  output ao_periph_pkg::reg_rsp_t reg_rsp_o,
  input  logic                    boot_select_i,
  output logic                    exit_valid_o,
  output logic [`AO_DATA_W-1:0]   exit_value_o
);
  import ao_periph_pkg::*;

  reg_rsp_t rsp;
  logic     wr_en;

  assign wr_en = reg_req_i.valid & reg_req_i.write;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exit_valid_o <= 1'b0;
      exit_value_o <= '0;
    end else if (wr_en) begin
      case (reg_req_i.addr.fld.ofs)
        `SOC_EXIT_VALID_OFS: exit_valid_o <= reg_req_i.wdata[0];
        `SOC_EXIT_VALUE_OFS: exit_value_o <= reg_req_i.wdata;
        default: ;
      endcase
    end
  end

  // Reads come straight from register state
  always_comb begin
    rsp       = '0;
    rsp.ready = reg_req_i.valid;
    if (reg_req_i.valid) begin
      case (reg_req_i.addr.fld.ofs)
        `SOC_EXIT_VALID_OFS: rsp.rdata[0] = exit_valid_o;
        `SOC_EXIT_VALUE_OFS: rsp.rdata = exit_value_o;
        // Pin level only, a write here does nothing
        `SOC_BOOT_SEL_OFS:   rsp.rdata[0] = boot_select_i;
        default:             rsp.error = 1'b1;
      endcase
    end
  end

  assign reg_rsp_o = rsp;

endmodule

// File: fast_intr_ctrl.sv
//----------------------------------------------------------------------
// Fast interrupt controller with sticky pending bits and enable mask
//----------------------------------------------------------------------
`timescale 1ns/1ns
`include "ao_periph_config.svh"

module fast_intr_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  ao_periph_pkg::reg_req_t reg_req_i,
  output ao_periph_pkg::reg_rsp_t reg_rsp_o,
  input  logic [`FAST_INTR_W-1:0] fast_intr_i,
  output logic [`FAST_INTR_W-1:0] fast_intr_o
);
  import ao_periph_pkg::*;

  logic [`FAST_INTR_W-1:0] pending_q;
  logic [`FAST_INTR_W-1:0] enable_q;
  logic [`FAST_INTR_W-1:0] clr_mask;
  logic                    wr_en;
  reg_rsp_t                rsp;

  assign wr_en = reg_req_i.valid & reg_req_i.write;

  // Write-one-to-clear mask
  always_comb begin
    clr_mask = '0;
    if (wr_en && (reg_req_i.addr.fld.ofs == `FI_CLEAR_OFS)) begin
      clr_mask = reg_req_i.wdata[`FAST_INTR_W-1:0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
      enable_q  <= '0;
    end else begin
      // A live input beats a clear of the same bit
      pending_q <= (pending_q & ~clr_mask) | fast_intr_i;
      if (wr_en && (reg_req_i.addr.fld.ofs == `FI_ENABLE_OFS)) begin
        enable_q <= reg_req_i.wdata[`FAST_INTR_W-1:0];
      end
    end
  end

  assign fast_intr_o = pending_q & enable_q;

  always_comb begin
    rsp       = '0;
    rsp.ready = reg_req_i.valid;
    if (reg_req_i.valid) begin
      case (reg_req_i.addr.fld.ofs)
        `FI_PENDING_OFS: rsp.rdata[`FAST_INTR_W-1:0] = pending_q;
        // Clear is write-only
        `FI_CLEAR_OFS:   rsp.rdata = '0;
        `FI_ENABLE_OFS:  rsp.rdata[`FAST_INTR_W-1:0] = enable_q;
        default:         rsp.error = 1'b1;
      endcase
    end
  end

  assign reg_rsp_o = rsp;

endmodule

// File: gpio_ao.sv
//----------------------------------------------------------------------
// GPIO port with output, enable, synchronized input and level interrupts
//----------------------------------------------------------------------
`timescale 1ns/1ns
`include "ao_periph_config.svh"

module gpio_ao (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  ao_periph_pkg::reg_req_t reg_req_i,
  output ao_periph_pkg::reg_rsp_t reg_rsp_o,
  input  logic [`GPIO_W-1:0]      cio_gpio_i,
  output logic [`GPIO_W-1:0]      cio_gpio_o,
  output logic [`GPIO_W-1:0]      cio_gpio_en_o,
  output logic [`GPIO_W-1:0]      intr_gpio_o
);
  import ao_periph_pkg::*;

  logic [`GPIO_W-1:0] sync_q1;
  logic [`GPIO_W-1:0] sync_q2;
  logic [`GPIO_W-1:0] out_q;
  logic [`GPIO_W-1:0] en_q;
  logic [`GPIO_W-1:0] intr_en_q;
  logic               wr_en;
  reg_rsp_t           rsp;

  assign wr_en = reg_req_i.valid & reg_req_i.write;

  // Two-flop synchronizer on the pad inputs
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= cio_gpio_i;
      sync_q2 <= sync_q1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_q     <= '0;
      en_q      <= '0;
      intr_en_q <= '0;
    end else if (wr_en) begin
      case (reg_req_i.addr.fld.ofs)
        `GPIO_OUT_OFS:     out_q <= reg_req_i.wdata[`GPIO_W-1:0];
        `GPIO_EN_OFS:      en_q <= reg_req_i.wdata[`GPIO_W-1:0];
        `GPIO_INTR_EN_OFS: intr_en_q <= reg_req_i.wdata[`GPIO_W-1:0];
        default: ;
      endcase
    end
  end

  assign cio_gpio_o    = out_q;
  assign cio_gpio_en_o = en_q;
  // Level interrupt per pin
  assign intr_gpio_o   = sync_q2 & intr_en_q;

  always_comb begin
    rsp       = '0;
    rsp.ready = reg_req_i.valid;
    if (reg_req_i.valid) begin
      case (reg_req_i.addr.fld.ofs)
        `GPIO_IN_OFS:      rsp.rdata[`GPIO_W-1:0] = sync_q2;
        `GPIO_OUT_OFS:     rsp.rdata[`GPIO_W-1:0] = out_q;
        `GPIO_EN_OFS:      rsp.rdata[`GPIO_W-1:0] = en_q;
        `GPIO_INTR_EN_OFS: rsp.rdata[`GPIO_W-1:0] = intr_en_q;
        default:           rsp.error = 1'b1;
      endcase
    end
  end

  assign reg_rsp_o = rsp;

endmodule

// File: ao_peripheral_subsystem.sv
//----------------------------------------------------------------------
// Always-on peripheral block with bus decode and three peripherals
//----------------------------------------------------------------------
`timescale 1ns/1ns
`include "ao_periph_config.svh"

module ao_peripheral_subsystem (
  input  logic                    clk_i,
  input  logic                    rst_n_i,

  input  ao_periph_pkg::reg_req_t bus_req_i,
  output ao_periph_pkg::reg_rsp_t bus_rsp_o,

  // SoC control
  input  logic                    boot_select_i,
  output logic                    exit_valid_o,
  output logic [`AO_DATA_W-1:0]   exit_value_o,

  // Fast interrupts
  input  logic [`FAST_INTR_W-1:0] fast_intr_i,
  output logic [`FAST_INTR_W-1:0] fast_intr_o,

  // GPIO pads
  input  logic [`GPIO_W-1:0]      cio_gpio_i,
  output logic [`GPIO_W-1:0]      cio_gpio_o,
  output logic [`GPIO_W-1:0]      cio_gpio_en_o,
  output logic [`GPIO_W-1:0]      intr_gpio_o
);
  import ao_periph_pkg::*;

  reg_req_t soc_req;
  reg_rsp_t soc_rsp;
  reg_req_t fi_req;
  reg_rsp_t fi_rsp;
  reg_req_t gpio_req;
  reg_rsp_t gpio_rsp;

  ao_reg_demux ao_reg_demux_inst (
    .bus_req_i  (bus_req_i),
    .bus_rsp_o  (bus_rsp_o),
    .soc_req_o  (soc_req),
    .soc_rsp_i  (soc_rsp),
    .fi_req_o   (fi_req),
    .fi_rsp_i   (fi_rsp),
    .gpio_req_o (gpio_req),
    .gpio_rsp_i (gpio_rsp)
  );

  soc_ctrl soc_ctrl_inst (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .reg_req_i     (soc_req),
    .reg_rsp_o     (soc_rsp),
    .boot_select_i (boot_select_i),
    .exit_valid_o  (exit_valid_o),
    .exit_value_o  (exit_value_o)
  );

  fast_intr_ctrl fast_intr_ctrl_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .reg_req_i   (fi_req),
    .reg_rsp_o   (fi_rsp),
    .fast_intr_i (fast_intr_i),
    .fast_intr_o (fast_intr_o)
  );

  gpio_ao gpio_ao_inst (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .reg_req_i     (gpio_req),
    .reg_rsp_o     (gpio_rsp),
    .cio_gpio_i    (cio_gpio_i),
    .cio_gpio_o    (cio_gpio_o),
    .cio_gpio_en_o (cio_gpio_en_o),
    .intr_gpio_o   (intr_gpio_o)
  );

endmodule

// File: ao_peripheral_subsystem_chk.sv
//----------------------------------------------------------------------
// Bus and output assertions for the AO peripheral block
// Attached to the top level with bind
//----------------------------------------------------------------------
`timescale 1ns/1ns
`include "ao_periph_config.svh"

module ao_peripheral_subsystem_chk (
  input logic                    clk_i,
  input logic                    rst_n_i,
  input ao_periph_pkg::reg_req_t bus_req_i,
  input ao_periph_pkg::reg_rsp_t bus_rsp_i,
  input logic                    exit_valid_i,
  input logic [`AO_DATA_W-1:0]   exit_value_i,
  input logic [`FAST_INTR_W-1:0] fi_irq_i,
  input logic [`GPIO_W-1:0]      gpio_out_i,
  input logic [`GPIO_W-1:0]      gpio_en_i,
  input logic [`GPIO_W-1:0]      gpio_irq_i
);

  logic                    fi_enable_wr;
  logic [`FAST_INTR_W-1:0] fi_enable_q;
  int                      fail_cnt = 0;

  // Enable mask as last written over the bus
  assign fi_enable_wr = bus_req_i.valid && bus_req_i.write &&
                        (bus_req_i.addr.word ==
                         {`AO_BASE_HI, `AO_IDX_FAST_INTR, `FI_ENABLE_OFS});

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      fi_enable_q <= '0;
    end else if (fi_enable_wr) begin
      fi_enable_q <= bus_req_i.wdata[`FAST_INTR_W-1:0];
    end
  end

  // Same-cycle handshake
  ready_follows_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bus_rsp_i.ready == bus_req_i.valid)
    else begin
      fail_cnt++;
      $error("bus ready differs from valid");
    end

  error_reads_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bus_rsp_i.error |-> (bus_rsp_i.rdata == '0))
    else begin
      fail_cnt++;
      $error("error response carries nonzero rdata");
    end

  outputs_clear_after_reset: assert property (@(posedge clk_i)
    !rst_n_i |=> (!exit_valid_i && (exit_value_i == '0) && (fi_irq_i == '0) &&
                  (gpio_out_i == '0) && (gpio_en_i == '0) && (gpio_irq_i == '0)))
    else begin
      fail_cnt++;
      $error("outputs not zero after reset");
    end

  // Masked lines never reach the output
  no_disabled_irq: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (fi_irq_i & ~fi_enable_q) == '0)
    else begin
      fail_cnt++;
      $error("fast interrupt output has a disabled bit");
    end

endmodule

bind ao_peripheral_subsystem ao_peripheral_subsystem_chk ao_peripheral_subsystem_chk_inst (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .bus_req_i    (bus_req_i),
  .bus_rsp_i    (bus_rsp_o),
  .exit_valid_i (exit_valid_o),
  .exit_value_i (exit_value_o),
  .fi_irq_i     (fast_intr_o),
  .gpio_out_i   (cio_gpio_o),
  .gpio_en_i    (cio_gpio_en_o),
  .gpio_irq_i   (intr_gpio_o)
);

// File: tb_ao_peripheral_subsystem.sv
//----------------------------------------------------------------------
// Testbench for the AO peripheral block
// Clock, reset, stimulus, reference model and compare process
//----------------------------------------------------------------------
`timescale 1ns/1ns
`include "ao_periph_config.svh"

module tb_ao_peripheral_subsystem;
  import ao_periph_pkg::*;

  localparam int TIMEOUT = 20;

  logic                    clk_i;
  logic                    rst_n_i;
  reg_req_t                bus_req;
  reg_rsp_t                bus_rsp;
  logic                    boot_select;
  logic                    exit_valid;
  logic [`AO_DATA_W-1:0]   exit_value;
  logic [`FAST_INTR_W-1:0] fast_intr_in;
  logic [`FAST_INTR_W-1:0] fast_intr_out;
  logic [`GPIO_W-1:0]      gpio_in;
  logic [`GPIO_W-1:0]      gpio_out;
  logic [`GPIO_W-1:0]      gpio_en;
  logic [`GPIO_W-1:0]      gpio_intr;

  // Shadow copy of the register state
  logic                    m_exit_valid;
  logic [`AO_DATA_W-1:0]   m_exit_value;
  logic [`FAST_INTR_W-1:0] m_pending;
  logic [`FAST_INTR_W-1:0] m_enable;
  logic [`GPIO_W-1:0]      m_out;
  logic [`GPIO_W-1:0]      m_en;
  logic [`GPIO_W-1:0]      m_intr_en;
  logic [`GPIO_W-1:0]      m_sync1;
  logic [`GPIO_W-1:0]      m_sync2;

  logic [31:0]             rnd;
  logic [15:0]             bad_hi;
  logic [3:0]              bad_idx;
  int                      i;

  ao_peripheral_subsystem ao_peripheral_subsystem_inst (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .bus_req_i     (bus_req),
    .bus_rsp_o     (bus_rsp),
    .boot_select_i (boot_select),
    .exit_valid_o  (exit_valid),
    .exit_value_o  (exit_value),
    .fast_intr_i   (fast_intr_in),
    .fast_intr_o   (fast_intr_out),
    .cio_gpio_i    (gpio_in),
    .cio_gpio_o    (gpio_out),
    .cio_gpio_en_o (gpio_en),
    .intr_gpio_o   (gpio_intr)
  );

  always #2 clk_i = ~clk_i;

  task automatic check_value(input string what, input logic [`AO_DATA_W-1:0] got,
                             input logic [`AO_DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("TB FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // Expected {error, rdata} from the address map and the shadow state
  function automatic logic [`AO_DATA_W:0] expected_read(input logic [`AO_ADDR_W-1:0] addr);
    logic [`AO_DATA_W-1:0] d;
    logic                  err;
    d   = '0;
    err = 1'b0;
    if (addr[31:16] != `AO_BASE_HI) begin
      err = 1'b1;
    end else if (addr[15:12] == `AO_IDX_SOC_CTRL) begin
      case (addr[11:0])
        `SOC_EXIT_VALID_OFS: d[0] = m_exit_valid;
        `SOC_EXIT_VALUE_OFS: d = m_exit_value;
        `SOC_BOOT_SEL_OFS:   d[0] = boot_select;
        default:             err = 1'b1;
      endcase
    end else if (addr[15:12] == `AO_IDX_FAST_INTR) begin
      case (addr[11:0])
        `FI_PENDING_OFS: d[`FAST_INTR_W-1:0] = m_pending;
        `FI_CLEAR_OFS:   d = '0;
        `FI_ENABLE_OFS:  d[`FAST_INTR_W-1:0] = m_enable;
        default:         err = 1'b1;
      endcase
    end else if (addr[15:12] == `AO_IDX_GPIO) begin
      case (addr[11:0])
        `GPIO_IN_OFS:      d[`GPIO_W-1:0] = m_sync2;
        `GPIO_OUT_OFS:     d[`GPIO_W-1:0] = m_out;
        `GPIO_EN_OFS:      d[`GPIO_W-1:0] = m_en;
        `GPIO_INTR_EN_OFS: d[`GPIO_W-1:0] = m_intr_en;
        default:           err = 1'b1;
      endcase
    end else begin
      err = 1'b1;
    end
    return {err, d};
  endfunction

  // Effect of an accepted write on the shadow state
  task automatic model_write(input logic [`AO_ADDR_W-1:0] addr,
                             input logic [`AO_DATA_W-1:0] data,
                             output logic [`FAST_INTR_W-1:0] clr);
    clr = '0;
    if (addr[15:12] == `AO_IDX_SOC_CTRL) begin
      case (addr[11:0])
        `SOC_EXIT_VALID_OFS: m_exit_valid = data[0];
        `SOC_EXIT_VALUE_OFS: m_exit_value = data;
        default: ;
      endcase
    end else if (addr[15:12] == `AO_IDX_FAST_INTR) begin
      case (addr[11:0])
        `FI_CLEAR_OFS:  clr = data[`FAST_INTR_W-1:0];
        `FI_ENABLE_OFS: m_enable = data[`FAST_INTR_W-1:0];
        default: ;
      endcase
    end else begin
      case (addr[11:0])
        `GPIO_OUT_OFS:     m_out = data[`GPIO_W-1:0];
        `GPIO_EN_OFS:      m_en = data[`GPIO_W-1:0];
        `GPIO_INTR_EN_OFS: m_intr_en = data[`GPIO_W-1:0];
        default: ;
      endcase
    end
  endtask

  // Compare at the rising edge, then advance the shadow state
  always @(posedge clk_i) begin : compare
    logic [`AO_DATA_W:0]     exp_rd;
    logic [`FAST_INTR_W-1:0] clr;
    clr = '0;
    if (!rst_n_i) begin
      m_exit_valid = 1'b0;
      m_exit_value = '0;
      m_pending    = '0;
      m_enable     = '0;
      m_out        = '0;
      m_en         = '0;
      m_intr_en    = '0;
      m_sync1      = '0;
      m_sync2      = '0;
    end else begin
      check_value("exit_valid_o", 32'(exit_valid), 32'(m_exit_valid));
      check_value("exit_value_o", exit_value, m_exit_value);
      check_value("fast_intr_o", 32'(fast_intr_out), 32'(m_pending & m_enable));
      check_value("cio_gpio_o", 32'(gpio_out), 32'(m_out));
      check_value("cio_gpio_en_o", 32'(gpio_en), 32'(m_en));
      check_value("intr_gpio_o", 32'(gpio_intr), 32'(m_sync2 & m_intr_en));
      if (bus_req.valid) begin
        exp_rd = expected_read(bus_req.addr.word);
        check_value("ready", 32'(bus_rsp.ready), 32'(1'b1));
        check_value("error", 32'(bus_rsp.error), 32'(exp_rd[`AO_DATA_W]));
        check_value("rdata", bus_rsp.rdata, exp_rd[`AO_DATA_W-1:0]);
        if (bus_req.write && !exp_rd[`AO_DATA_W]) begin
          model_write(bus_req.addr.word, bus_req.wdata, clr);
        end
      end
      // Live input wins over a clear of the same bit
      m_pending = (m_pending & ~clr) | fast_intr_in;
      m_sync2   = m_sync1;
      m_sync1   = gpio_in;
    end
  end

  function automatic logic [`AO_ADDR_W-1:0] reg_addr(input logic [3:0] idx,
                                                     input logic [11:0] ofs);
    return {`AO_BASE_HI, idx, ofs};
  endfunction

  // One access driven on the falling edge and held until ready
  task automatic bus_access(input logic [`AO_ADDR_W-1:0] addr, input logic write,
                            input logic [`AO_DATA_W-1:0] data);
    int cnt;
    @(negedge clk_i);
    bus_req.addr.word = addr;
    bus_req.write     = write;
    bus_req.wdata     = data;
    bus_req.valid     = 1'b1;
    cnt = 0;
    @(posedge clk_i);
    while (!bus_rsp.ready) begin
      if (cnt == TIMEOUT) begin
        $display("Timeout: no ready on the bus for address %h", addr);
        $display("TB FAILED");
        $fatal(1, "bus timeout");
      end
      cnt++;
      @(posedge clk_i);
    end
    @(negedge clk_i);
    bus_req.valid = 1'b0;
    bus_req.write = 1'b0;
  endtask

  task automatic write_reg(input logic [3:0] idx, input logic [11:0] ofs,
                           input logic [`AO_DATA_W-1:0] data);
    bus_access(reg_addr(idx, ofs), 1'b1, data);
  endtask

  task automatic read_reg(input logic [3:0] idx, input logic [11:0] ofs);
    bus_access(reg_addr(idx, ofs), 1'b0, '0);
  endtask

  task automatic read_all();
    read_reg(`AO_IDX_SOC_CTRL, `SOC_EXIT_VALID_OFS);
    read_reg(`AO_IDX_SOC_CTRL, `SOC_EXIT_VALUE_OFS);
    read_reg(`AO_IDX_SOC_CTRL, `SOC_BOOT_SEL_OFS);
    read_reg(`AO_IDX_FAST_INTR, `FI_PENDING_OFS);
    read_reg(`AO_IDX_FAST_INTR, `FI_CLEAR_OFS);
    read_reg(`AO_IDX_FAST_INTR, `FI_ENABLE_OFS);
    read_reg(`AO_IDX_GPIO, `GPIO_IN_OFS);
    read_reg(`AO_IDX_GPIO, `GPIO_OUT_OFS);
    read_reg(`AO_IDX_GPIO, `GPIO_EN_OFS);
    read_reg(`AO_IDX_GPIO, `GPIO_INTR_EN_OFS);
  endtask

  initial begin
    rnd          = $urandom(32'h9b63);
    clk_i        = 1'b0;
    rst_n_i      = 1'b0;
    bus_req      = '0;
    boot_select  = 1'b1;
    fast_intr_in = '0;
    gpio_in      = '0;
    repeat (8) @(negedge clk_i);
    rst_n_i = 1'b1;

    // Reset values
    read_all();

    // SoC control
    for (i = 0; i < 8; i++) begin
      rnd = $urandom;
      write_reg(`AO_IDX_SOC_CTRL, `SOC_EXIT_VALUE_OFS, rnd);
      rnd = $urandom;
      write_reg(`AO_IDX_SOC_CTRL, `SOC_EXIT_VALID_OFS, rnd);
      boot_select = rnd[5];
      read_reg(`AO_IDX_SOC_CTRL, `SOC_EXIT_VALUE_OFS);
      read_reg(`AO_IDX_SOC_CTRL, `SOC_EXIT_VALID_OFS);
      read_reg(`AO_IDX_SOC_CTRL, `SOC_BOOT_SEL_OFS);
    end

    // Fast interrupt pulses and clears with some inputs still high
    rnd = $urandom;
    write_reg(`AO_IDX_FAST_INTR, `FI_ENABLE_OFS, rnd);
    for (i = 0; i < 10; i++) begin
      rnd = $urandom;
      @(negedge clk_i);
      fast_intr_in = rnd[14:0] & rnd[30:16];
      @(negedge clk_i);
      fast_intr_in = '0;
      read_reg(`AO_IDX_FAST_INTR, `FI_PENDING_OFS);
      if (i == 5) begin
        write_reg(`AO_IDX_FAST_INTR, `FI_ENABLE_OFS, $urandom);
      end
      rnd = $urandom;
      fast_intr_in = rnd[14:0] & rnd[29:15];
      rnd = $urandom;
      write_reg(`AO_IDX_FAST_INTR, `FI_CLEAR_OFS, rnd);
      fast_intr_in = '0;
      read_reg(`AO_IDX_FAST_INTR, `FI_PENDING_OFS);
    end
    write_reg(`AO_IDX_FAST_INTR, `FI_CLEAR_OFS, 32'hffff_ffff);
    read_reg(`AO_IDX_FAST_INTR, `FI_PENDING_OFS);

    // GPIO
    for (i = 0; i < 8; i++) begin
      rnd = $urandom;
      write_reg(`AO_IDX_GPIO, `GPIO_OUT_OFS, rnd);
      write_reg(`AO_IDX_GPIO, `GPIO_EN_OFS, rnd >> 8);
      write_reg(`AO_IDX_GPIO, `GPIO_INTR_EN_OFS, rnd >> 16);
      gpio_in = rnd[31:24];
      read_reg(`AO_IDX_GPIO, `GPIO_IN_OFS);
      repeat (2) @(negedge clk_i);
      read_reg(`AO_IDX_GPIO, `GPIO_IN_OFS);
      read_reg(`AO_IDX_GPIO, `GPIO_OUT_OFS);
      read_reg(`AO_IDX_GPIO, `GPIO_EN_OFS);
      read_reg(`AO_IDX_GPIO, `GPIO_INTR_EN_OFS);
    end

    // Decode errors leave every register unchanged
    for (i = 0; i < 8; i++) begin
      rnd     = $urandom;
      bad_hi  = (rnd[31:16] == `AO_BASE_HI) ? 16'h2001 : rnd[31:16];
      bad_idx = (rnd[3:0] < 4'd3) ? rnd[3:0] + 4'd3 : rnd[3:0];
      bus_access({bad_hi, rnd[15:0]}, 1'b1, rnd);
      bus_access({bad_hi, rnd[15:0]}, 1'b0, '0);
      bus_access(reg_addr(bad_idx, rnd[11:0]), 1'b1, rnd);
      bus_access(reg_addr(bad_idx, rnd[11:0]), 1'b0, '0);
      write_reg(`AO_IDX_SOC_CTRL, 12'h010 | rnd[11:0], rnd);
      write_reg(`AO_IDX_FAST_INTR, 12'h010 | rnd[11:0], rnd);
      write_reg(`AO_IDX_GPIO, 12'h010 | rnd[11:0], rnd);
      read_reg(`AO_IDX_GPIO, 12'h010 | rnd[11:0]);
    end
    read_all();

    repeat (2) @(negedge clk_i);
    if (ao_peripheral_subsystem_inst.ao_peripheral_subsystem_chk_inst.fail_cnt != 0) begin
      $display("Assertions in the bound checker failed %0d times",
               ao_peripheral_subsystem_inst.ao_peripheral_subsystem_chk_inst.fail_cnt);
      $display("TB FAILED");
      $fatal(1, "assertion failures");
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

// File: ao_peripheral_subsystem.f
+incdir+.
ao_periph_pkg.sv
ao_reg_demux.sv
soc_ctrl.sv
fast_intr_ctrl.sv
gpio_ao.sv
ao_peripheral_subsystem.sv
ao_peripheral_subsystem_chk.sv
tb_ao_peripheral_subsystem.sv

// File: Makefile
# Verilator build and run for the AO peripheral block

VERILATOR ?= verilator
TOP       ?= tb_ao_peripheral_subsystem
FILELIST  ?= ao_peripheral_subsystem.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TB PASSED
FAIL_MSG  ?= TB FAILED

SOURCES := $(wildcard *.sv *.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
